//--- hdl/afu_pkg.sv
//////////////////////////////////////////////////
// Accelerator-side types
// Engine ids, job ranges, queue status, restart FSM
//////////////////////////////////////////////////

package afu_pkg;

	// Engine number, all ones is reserved
	typedef logic [3:0] cu_id_t;

	localparam cu_id_t RESTART_ID = '1;

	typedef enum logic {
		CMD_READ    = 1'b0,
		CMD_RESTART = 1'b1
	} cmd_type_t;

	// Number of cache lines in a job or a share
	typedef logic [15:0] line_count_t;

	typedef struct packed {
		logic [31:0] base;
		line_count_t count;
	} job_t;

	typedef struct packed {
		logic full;
		logic alfull;
		logic valid;
		logic empty;
	} queue_status_t;

	typedef enum logic [2:0] {
		RESTART_RESET,
		RESTART_IDLE,
		RESTART_INIT,
		RESTART_SEND_CMD,
		RESTART_RESP_WAIT,
		RESTART_SEND_CMD_FLUSHED,
		RESTART_DONE
	} restart_state_t;

endpackage

//--- hdl/psl_pkg.sv
//////////////////////////////////////////////////
// Bus protocol types
// Command and response lines, tags and addresses
//////////////////////////////////////////////////

package psl_pkg;

	import afu_pkg::cu_id_t;
	import afu_pkg::cmd_type_t;

	typedef logic [7:0] tag_t;

	// Cache-line address, not a byte address
	typedef logic [31:0] addr_t;

	typedef enum logic [1:0] {
		READ    = 2'd0,
		RESTART = 2'd1
	} psl_cmd_t;

	typedef enum logic [1:0] {
		DONE    = 2'd0,
		PAGED   = 2'd1,
		FLUSHED = 2'd2
	} psl_response_t;

	typedef enum logic {
		ABORT  = 1'b0,
		STRICT = 1'b1
	} abort_t;

	typedef struct packed {
		logic      valid;
		psl_cmd_t  command;
		abort_t    abt;
		tag_t      tag;
		addr_t     address;
		cu_id_t    cu_id;
		cmd_type_t cmd_type;
	} cmd_line_t;

	typedef struct packed {
		logic          valid;
		tag_t          tag;
		psl_response_t response;
	} rsp_line_t;

endpackage

//--- hdl/restart_fifo.sv
//////////////////////////////////////////////////
// Replay FIFO
// Circular buffer with status flags
//////////////////////////////////////////////////

module restart_fifo #(
	parameter int WIDTH = 49,
	parameter int DEPTH = 8
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	output logic             full,
	output logic             alfull,
	input  logic             pop,
	output logic             valid,
	output logic [WIDTH-1:0] data_out,
	output logic             empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [AW:0]      count;
	logic             do_push;
	logic             do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= data_in;
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Show-ahead read
	assign data_out = mem[rd_ptr];
	assign empty    = (count == '0);
	assign valid    = !empty;
	assign full     = (count == (AW+1)'(DEPTH));
	assign alfull   = (count >= (AW+1)'(DEPTH - 1));

endmodule

//--- hdl/job_dispatch.sv
//////////////////////////////////////////////////
// Job dispatcher
// Splits a read job evenly over the engines
//////////////////////////////////////////////////

module job_dispatch #(
	parameter int NUM_CU = 4
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         job_start,
	input  afu_pkg::job_t                job,
	output logic [NUM_CU-1:0]            cu_start,
	output afu_pkg::job_t [NUM_CU-1:0]   cu_job,
	input  logic [NUM_CU-1:0]            cu_idle,
	output logic                         job_done
);
	import afu_pkg::*;

	line_count_t              share;
	line_count_t              extra;
	job_t [NUM_CU-1:0]        split;
	logic                     busy;
	logic                     start_d;

	// Low-numbered engines take one extra line each
	always_comb begin
		share = job.count / line_count_t'(NUM_CU);
		extra = job.count % line_count_t'(NUM_CU);
		for (int i = 0; i < NUM_CU; i++) begin
			if (line_count_t'(i) < extra) begin
				split[i].count = share + 1'b1;
				split[i].base  = job.base + 32'(i) * 32'(share) + 32'(i);
			end else begin
				split[i].count = share;
				split[i].base  = job.base + 32'(i) * 32'(share) + 32'(extra);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (job_start)
			cu_job <= split;
	end

	// Idle flags settle two cycles after the start pulse
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_start <= '0;
			start_d  <= 1'b0;
			busy     <= 1'b0;
			job_done <= 1'b0;
		end else begin
			start_d <= |cu_start;
			if (job_start) begin
				cu_start <= '1;
				busy     <= 1'b1;
				job_done <= 1'b0;
			end else begin
				cu_start <= '0;
				if (busy && !start_d && !(|cu_start) && (&cu_idle)) begin
					busy     <= 1'b0;
					job_done <= 1'b1;
				end
			end
		end
	end

endmodule

//--- hdl/cu_cmd_engine.sv
//////////////////////////////////////////////////
// Compute-unit command engine
// Walks a line range, one READ per grant
//////////////////////////////////////////////////

module cu_cmd_engine #(
	parameter afu_pkg::cu_id_t CU_ID = '0
) (
	input  logic               clock,
	input  logic               rstn,
	input  logic               start,
	input  afu_pkg::job_t      range,
	input  logic               grant,
	output logic               request,
	output logic               idle,
	output psl_pkg::cmd_line_t cmd
);
	import afu_pkg::*;
	import psl_pkg::*;

	addr_t       next_addr;
	line_count_t remaining;

	//////////////////////////////////////////////////
	// Range walker
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			remaining <= '0;
		end else if (start) begin
			remaining <= range.count;
		end else if (grant) begin
			remaining <= remaining - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (start)
			next_addr <= range.base;
		else if (grant)
			next_addr <= next_addr + 1'b1;
	end

	assign request = (remaining != '0);
	assign idle    = (remaining == '0);

	// Tag is left zero, the arbiter stamps it
	always_comb begin
		cmd          = '0;
		cmd.valid    = request;
		cmd.command  = READ;
		cmd.abt      = ABORT;
		cmd.address  = next_addr;
		cmd.cu_id    = CU_ID;
		cmd.cmd_type = CMD_READ;
	end

	// The arbiter must only grant a live request
	a_grant_needs_request: assert property (
		@(posedge clock) disable iff (!rstn) grant |-> request
	) else $error("grant to engine %0d without request", CU_ID);

endmodule

//--- hdl/cmd_arbiter.sv
//////////////////////////////////////////////////
// Command arbiter
// Round-robin grants, tags, credits, restart merge
//////////////////////////////////////////////////

module cmd_arbiter #(
	parameter int NUM_CU        = 4,
	parameter int CREDITS_TOTAL = 8
) (
	input  logic                            clock,
	input  logic                            rstn,
	input  logic                            enabled,
	input  logic [NUM_CU-1:0]               request,
	input  psl_pkg::cmd_line_t [NUM_CU-1:0] cu_cmd,
	input  psl_pkg::cmd_line_t              restart_cmd,
	input  logic                            hold,
	input  logic                            credit_return,
	output logic [NUM_CU-1:0]               grant,
	output psl_pkg::cmd_line_t              command,
	output logic [7:0]                      credits
);
	import psl_pkg::*;

	localparam int IW = (NUM_CU > 1) ? $clog2(NUM_CU) : 1;

	logic [IW-1:0] last;
	logic [IW-1:0] winner;
	logic          found;
	logic          can_grant;
	logic          spend;
	tag_t          next_tag;

	// Search starts one past the last winner
	always_comb begin
		int idx;
		found  = 1'b0;
		winner = last;
		for (int k = 1; k <= NUM_CU; k++) begin
			idx = (int'(last) + k) % NUM_CU;
			if (!found && request[idx]) begin
				found  = 1'b1;
				winner = IW'(idx);
			end
		end
	end

	assign can_grant = enabled && !hold && !restart_cmd.valid && (credits != 8'd0);

	always_comb begin
		grant = '0;
		if (can_grant && found)
			grant[winner] = 1'b1;
	end

	// Restart and replay traffic bypasses the engines
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			command  <= '0;
			last     <= '0;
			next_tag <= '0;
		end else if (restart_cmd.valid) begin
			command <= restart_cmd;
		end else if (|grant) begin
			command     <= cu_cmd[winner];
			command.tag <= next_tag;
			last        <= winner;
			next_tag    <= next_tag + 1'b1;
		end else begin
			command <= '0;
		end
	end

	//////////////////////////////////////////////////
	// Credits
	//////////////////////////////////////////////////

	// Every command on the bus holds one credit
	assign spend = restart_cmd.valid || (|grant);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			credits <= 8'(CREDITS_TOTAL);
		end else begin
			case ({spend, credit_return})
				2'b10: credits <= credits - 8'd1;
				2'b01: credits <= credits + 8'd1;
				default: credits <= credits;
			endcase
		end
	end

	a_credit_bound: assert property (
		@(posedge clock) disable iff (!rstn) credits <= 8'(CREDITS_TOTAL)
	) else $error("credit count %0d above total", credits);

endmodule

//--- hdl/restart_control.sv
//////////////////////////////////////////////////
// Page-fault restart controller
// Tag record, RESTART issue and replay of failures
//////////////////////////////////////////////////

module restart_control #(
	parameter int CREDITS_TOTAL = 8
) (
	input  logic               clock,
	input  logic               enabled_in,
	input  logic               rstn,
	input  psl_pkg::cmd_line_t command_outstanding_in,
	input  psl_pkg::tag_t      command_tag_in,
	input  psl_pkg::rsp_line_t restart_response_in,
	input  psl_pkg::rsp_line_t response,
	input  logic [7:0]         credits_in,
	output logic               ready_restart_issue,
	output psl_pkg::cmd_line_t restart_command_out,
	output logic               restart_command_flushed,
	output logic               restart_pending
);
	import afu_pkg::*;
	import psl_pkg::*;

	logic           enabled;
	cmd_line_t      tag_record [2**$bits(tag_t)];
	cmd_line_t      rec_in;
	tag_t           rd_tag;
	cmd_line_t      rec_rd;
	psl_response_t  rsp_kind_q;
	logic           fill_rd;
	logic           fill_rd_s2;
	logic           buffer_push;
	cmd_line_t      buffer_in;
	cmd_line_t      replay_head;
	logic           replay_pop;
	logic           replay_drained;
	queue_status_t  buffer_status;
	restart_state_t current_state;
	restart_state_t next_state;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			enabled <= 1'b0;
		else
			enabled <= enabled_in;
	end

	//////////////////////////////////////////////////
	// Tag record and replay fill
	//////////////////////////////////////////////////

	always_comb begin
		rec_in     = command_outstanding_in;
		rec_in.tag = command_tag_in;
	end

	// Latch the failure, read its record, then push
	always_ff @(posedge clock) begin
		if (enabled) begin
			if (command_outstanding_in.valid)
				tag_record[command_tag_in] <= rec_in;
			rd_tag     <= response.tag;
			rsp_kind_q <= response.response;
			rec_rd     <= tag_record[rd_tag];
			buffer_in  <= rec_rd;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			fill_rd     <= 1'b0;
			fill_rd_s2  <= 1'b0;
			buffer_push <= 1'b0;
		end else if (enabled) begin
			fill_rd     <= response.valid;
			fill_rd_s2  <= fill_rd;
			buffer_push <= fill_rd_s2;
		end
	end

	restart_fifo #(
		.WIDTH($bits(cmd_line_t)),
		.DEPTH(CREDITS_TOTAL)
	) restart_fifo_i (
		.clock   (clock),
		.rstn    (rstn),
		.push    (buffer_push),
		.data_in (buffer_in),
		.full    (buffer_status.full),
		.alfull  (buffer_status.alfull),
		.pop     (replay_pop),
		.valid   (buffer_status.valid),
		.data_out(replay_head),
		.empty   (buffer_status.empty)
	);

	assign replay_pop = (current_state == RESTART_SEND_CMD_FLUSHED) && buffer_status.valid;

	// Nothing queued, nothing in the fill pipe, all credits home
	assign replay_drained = buffer_status.empty && !fill_rd && !fill_rd_s2 && !buffer_push
		&& !restart_command_out.valid && (credits_in == 8'(CREDITS_TOTAL));

	//////////////////////////////////////////////////
	// Restart FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			current_state <= RESTART_RESET;
		else if (enabled)
			current_state <= next_state;
	end

	always_comb begin
		next_state = current_state;
		case (current_state)
			RESTART_RESET:
				next_state = RESTART_IDLE;
			RESTART_IDLE:
				if (response.valid)
					next_state = RESTART_INIT;
			RESTART_INIT:
				next_state = (rsp_kind_q == PAGED) ? RESTART_SEND_CMD : RESTART_SEND_CMD_FLUSHED;
			RESTART_SEND_CMD:
				next_state = RESTART_RESP_WAIT;
			RESTART_RESP_WAIT:
				if (restart_response_in.valid)
					next_state = RESTART_SEND_CMD_FLUSHED;
			RESTART_SEND_CMD_FLUSHED:
				if (response.valid && response.response == PAGED)
					next_state = RESTART_INIT;
				else if (replay_drained)
					next_state = RESTART_DONE;
			RESTART_DONE:
				next_state = response.valid ? RESTART_INIT : RESTART_IDLE;
			default:
				next_state = RESTART_RESET;
		endcase
	end

	// Outputs are registered, one cycle behind the state
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			ready_restart_issue     <= 1'b0;
			restart_pending         <= 1'b0;
			restart_command_out     <= '0;
			restart_command_flushed <= 1'b0;
		end else if (enabled) begin
			restart_command_out     <= '0;
			restart_command_flushed <= 1'b0;
			case (current_state)
				RESTART_RESET, RESTART_IDLE: begin
					ready_restart_issue <= 1'b0;
					restart_pending     <= 1'b0;
				end
				RESTART_INIT: begin
					ready_restart_issue <= 1'b1;
					restart_pending     <= 1'b1;
				end
				RESTART_SEND_CMD: begin
					// Reuses the faulted tag, free until the replay
					restart_command_out          <= rec_rd;
					restart_command_out.valid    <= 1'b1;
					restart_command_out.command  <= RESTART;
					restart_command_out.abt      <= STRICT;
					restart_command_out.cmd_type <= CMD_RESTART;
					restart_command_out.cu_id    <= RESTART_ID;
				end
				RESTART_SEND_CMD_FLUSHED: begin
					if (replay_pop) begin
						restart_command_out     <= replay_head;
						restart_command_out.abt <= STRICT;
						restart_command_flushed <= 1'b1;
					end
				end
				default: begin
				end
			endcase
		end
	end

	// Depth matches the credits, so failures cannot overrun it
	a_no_push_full: assert property (
		@(posedge clock) disable iff (!rstn) buffer_push |-> !buffer_status.full
	) else $error("replay FIFO push while full");

endmodule

//--- hdl/afu_top.sv
//////////////////////////////////////////////////
// Accelerator command path top level
//////////////////////////////////////////////////

module afu_top #(
	parameter int NUM_CU        = 4,
	parameter int CREDITS_TOTAL = 8
) (
	input  logic                 clock,
	input  logic                 rstn,
	input  logic                 enabled_in,
	input  logic                 job_start,
	input  afu_pkg::job_t        job,
	input  psl_pkg::rsp_line_t   response,
	output psl_pkg::cmd_line_t   command,
	output logic                 job_done,
	output logic                 restart_pending,
	output afu_pkg::line_count_t completions
);
	import afu_pkg::*;
	import psl_pkg::*;

	logic [NUM_CU-1:0]      cu_start;
	job_t [NUM_CU-1:0]      cu_job;
	logic [NUM_CU-1:0]      cu_idle;
	logic [NUM_CU-1:0]      cu_request;
	logic [NUM_CU-1:0]      cu_grant;
	cmd_line_t [NUM_CU-1:0] cu_cmd;
	cmd_line_t              restart_cmd;
	logic                   ready_restart_issue;
	logic                   restart_command_flushed;
	logic [7:0]             credits;
	logic                   restart_inflight;
	tag_t                   restart_tag;
	logic                   restart_hit;
	rsp_line_t              rc_response;
	rsp_line_t              rc_restart_response;

	//////////////////////////////////////////////////
	// Response split
	//////////////////////////////////////////////////

	// Track the one RESTART on the bus by its tag
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			restart_inflight <= 1'b0;
		else if (command.valid && command.cmd_type == CMD_RESTART)
			restart_inflight <= 1'b1;
		else if (restart_hit)
			restart_inflight <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (command.valid && command.cmd_type == CMD_RESTART)
			restart_tag <= command.tag;
	end

	assign restart_hit = response.valid && restart_inflight && (response.tag == restart_tag);

	always_comb begin
		rc_restart_response       = response;
		rc_restart_response.valid = restart_hit;
		rc_response               = response;
		rc_response.valid         = response.valid && !restart_hit && (response.response != DONE);
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			completions <= '0;
		else if (job_start)
			completions <= '0;
		else if (response.valid && !restart_hit && response.response == DONE)
			completions <= completions + 1'b1;
	end

	//////////////////////////////////////////////////
	// Blocks
	//////////////////////////////////////////////////

	job_dispatch #(.NUM_CU(NUM_CU)) job_dispatch_i (
		.clock   (clock),
		.rstn    (rstn),
		.job_start(job_start),
		.job     (job),
		.cu_start(cu_start),
		.cu_job  (cu_job),
		.cu_idle (cu_idle),
		.job_done(job_done)
	);

	for (genvar i = 0; i < NUM_CU; i++) begin : g_cu
		cu_cmd_engine #(.CU_ID(cu_id_t'(i))) cu_cmd_engine_i (
			.clock  (clock),
			.rstn   (rstn),
			.start  (cu_start[i]),
			.range  (cu_job[i]),
			.grant  (cu_grant[i]),
			.request(cu_request[i]),
			.idle   (cu_idle[i]),
			.cmd    (cu_cmd[i])
		);
	end

	// Every response, failed or not, gives its credit back
	cmd_arbiter #(
		.NUM_CU       (NUM_CU),
		.CREDITS_TOTAL(CREDITS_TOTAL)
	) cmd_arbiter_i (
		.clock        (clock),
		.rstn         (rstn),
		.enabled      (enabled_in),
		.request      (cu_request),
		.cu_cmd       (cu_cmd),
		.restart_cmd  (restart_cmd),
		.hold         (ready_restart_issue || restart_pending),
		.credit_return(response.valid),
		.grant        (cu_grant),
		.command      (command),
		.credits      (credits)
	);

	restart_control #(.CREDITS_TOTAL(CREDITS_TOTAL)) restart_control_i (
		.clock                  (clock),
		.enabled_in             (enabled_in),
		.rstn                   (rstn),
		.command_outstanding_in (command),
		.command_tag_in         (command.tag),
		.restart_response_in    (rc_restart_response),
		.response               (rc_response),
		.credits_in             (credits),
		.ready_restart_issue    (ready_restart_issue),
		.restart_command_out    (restart_cmd),
		.restart_command_flushed(restart_command_flushed),
		.restart_pending        (restart_pending)
	);

	// A replay reaches the bus one cycle later as a STRICT command
	a_replay_on_bus: assert property (
		@(posedge clock) disable iff (!rstn)
		restart_command_flushed |=> command.valid && command.abt == STRICT
	) else $error("replay did not reach the bus");

endmodule

//--- dv/afu_tb.sv
//////////////////////////////////////////////////
// Testbench for the accelerator command path
// Acts as the bus, answers from a response trace
//////////////////////////////////////////////////

module afu_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import afu_pkg::*;
	import psl_pkg::*;

	localparam int NUM_CU        = 4;
	localparam int CREDITS_TOTAL = 8;
	localparam int TRACE_WORDS   = 64;

	logic        clock = 1'b0;
	logic        rstn;
	logic        enabled_in;
	logic        job_start;
	job_t        job;
	rsp_line_t   response;
	cmd_line_t   command;
	logic        job_done;
	logic        restart_pending;
	line_count_t completions;

	logic [31:0] trace_mem [TRACE_WORDS];
	addr_t       job_base;
	int          line_count;
	int          kind_total;
	int          kind_idx = 0;
	int          cycles = 0;
	int          timeout_limit = 200;
	int          lines_done = 0;
	tag_t        expected_tag = '0;
	bit          issued [256];
	bit          done_line [256];
	bit          replay_due [256];
	bit          page_fault [256];
	cmd_line_t   orig [256];
	rsp_line_t   rsp_q [$];
	int          due_q [$];

	always #2 clock = ~clock;

	afu_top #(
		.NUM_CU       (NUM_CU),
		.CREDITS_TOTAL(CREDITS_TOTAL)
	) afu_top_i (
		.clock          (clock),
		.rstn           (rstn),
		.enabled_in     (enabled_in),
		.job_start      (job_start),
		.job            (job),
		.response       (response),
		.command        (command),
		.job_done       (job_done),
		.restart_pending(restart_pending),
		.completions    (completions)
	);

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_cmd(input cmd_line_t got, input cmd_line_t exp, input string what);
		if (got !== exp)
			report_error($sformatf("CHECK FAILED at %0d ns: %s got %h expected %h",
				$time, what, got, exp));
	endtask

	task automatic check_count(input line_count_t got, input line_count_t exp, input string what);
		if (got !== exp)
			report_error($sformatf("CHECK FAILED at %0d ns: %s is %0d, expected %0d",
				$time, what, got, exp));
	endtask

	// Even split, low engines take one extra line
	function automatic cu_id_t owner_of(input int off);
		int share;
		int extra;
		int big;
		share = line_count / NUM_CU;
		extra = line_count % NUM_CU;
		big   = extra * (share + 1);
		if (off < big)
			return cu_id_t'(off / (share + 1));
		return cu_id_t'(extra + (off - big) / share);
	endfunction

	task automatic answer_command(input cmd_line_t c);
		cmd_line_t     exp;
		psl_response_t kind;
		rsp_line_t     rsp;
		int            off;
		kind = DONE;
		if (c.cmd_type == CMD_RESTART) begin
			if (!page_fault[c.tag])
				report_error($sformatf("RESTART with tag %0d but no page fault on it", c.tag));
			exp          = orig[c.tag];
			exp.command  = RESTART;
			exp.abt      = STRICT;
			exp.cu_id    = RESTART_ID;
			exp.cmd_type = CMD_RESTART;
			check_cmd(c, exp, "RESTART command");
			page_fault[c.tag] = 1'b0;
		end else begin
			if (c.abt == STRICT) begin
				// Replay keeps the tag and address of the failed read
				if (!replay_due[c.tag])
					report_error($sformatf("Replay of tag %0d that never failed", c.tag));
				if (page_fault[c.tag])
					report_error($sformatf("Replay of tag %0d came before its RESTART", c.tag));
				exp     = orig[c.tag];
				exp.abt = STRICT;
				check_cmd(c, exp, "replayed command");
				replay_due[c.tag] = 1'b0;
			end else begin
				if (c.address < job_base || c.address - job_base >= addr_t'(line_count))
					report_error($sformatf("CHECK FAILED at %0d ns: read address %h outside the job",
						$time, c.address));
				off = int'(c.address - job_base);
				if (issued[off])
					report_error($sformatf("Line %h was issued twice by the engines", c.address));
				issued[off]  = 1'b1;
				exp          = '0;
				exp.valid    = 1'b1;
				exp.command  = READ;
				exp.abt      = ABORT;
				exp.tag      = expected_tag;
				exp.address  = c.address;
				exp.cu_id    = owner_of(off);
				exp.cmd_type = CMD_READ;
				check_cmd(c, exp, "engine read");
				orig[c.tag]  = c;
				expected_tag = expected_tag + 1'b1;
			end
			if (kind_idx < kind_total) begin
				kind = psl_response_t'(trace_mem[3 + kind_idx][1:0]);
				kind_idx++;
			end
			off = int'(c.address - job_base);
			if (kind == DONE) begin
				if (done_line[off])
					report_error($sformatf("Line %h was answered DONE twice", c.address));
				done_line[off] = 1'b1;
				lines_done++;
			end else begin
				replay_due[c.tag] = 1'b1;
				if (kind == PAGED)
					page_fault[c.tag] = 1'b1;
			end
		end
		rsp.valid    = 1'b1;
		rsp.tag      = c.tag;
		rsp.response = kind;
		rsp_q.push_back(rsp);
		due_q.push_back(cycles + 4);
		if (rsp_q.size() > CREDITS_TOTAL)
			report_error($sformatf("More than %0d commands unanswered on the bus", CREDITS_TOTAL));
	endtask

	//////////////////////////////////////////////////
	// Bus responder
	//////////////////////////////////////////////////

	always @(posedge clock) begin
		if (rstn) begin
			cycles++;
			if (cycles > timeout_limit) begin
				report_error($sformatf("Timeout: job not finished after %0d cycles", timeout_limit));
			end else begin
				if (due_q.size() > 0 && due_q[0] == cycles) begin
					response <= rsp_q.pop_front();
					due_q.delete(0);
				end else begin
					response <= '0;
				end
				if (command.valid)
					answer_command(command);
			end
		end
	end

	initial begin
		rstn       = 1'b0;
		enabled_in = 1'b1;
		job_start  = 1'b0;
		job        = '0;
		response   = '0;
		$readmemh("dv/afu_trace.txt", trace_mem);
		if ($isunknown(trace_mem[1]) || trace_mem[1] == 0 || trace_mem[1] > 256
			|| trace_mem[2] > TRACE_WORDS - 3)
			report_error("Trace file dv/afu_trace.txt is missing or out of range");
		job_base      = trace_mem[0];
		line_count    = int'(trace_mem[1]);
		kind_total    = int'(trace_mem[2]);
		timeout_limit = 50 * line_count + 200;

		repeat (3) @(posedge clock);
		rstn <= 1'b1;

		// Bus stays quiet until the job starts
		repeat (4) begin
			@(negedge clock);
			if (command.valid || restart_pending || job_done)
				report_error("Command, job_done or restart_pending active before job_start");
		end

		@(posedge clock);
		job.base  <= job_base;
		job.count <= line_count_t'(line_count);
		job_start <= 1'b1;
		@(posedge clock);
		job_start <= 1'b0;

		// Every line answered DONE and the restart path idle again
		do begin
			@(negedge clock);
		end while (!(job_done && !restart_pending && lines_done == line_count
			&& due_q.size() == 0 && !response.valid));
		check_count(completions, line_count_t'(line_count), "completion count");

		$display("Verification passed");
		$finish;
	end

endmodule

//--- dv/afu_trace.txt
// Job trace, one hex word per line
// Word 0 job base line, word 1 line count, word 2 number of response kinds
// Then one kind per observed READ or replay: 0 DONE, 1 PAGED, 2 FLUSHED
// RESTART commands are always answered DONE and take no entry
00001000
00000016
00000014
00000000
00000000
00000000
00000001
00000000
00000000
00000000
00000000
00000002
00000000
00000000
00000000
00000001
00000002
00000000
00000000
00000000
00000000
00000002
00000000

//--- vlog.f
hdl/afu_pkg.sv
hdl/psl_pkg.sv
hdl/restart_fifo.sv
hdl/job_dispatch.sv
hdl/cu_cmd_engine.sv
hdl/cmd_arbiter.sv
hdl/restart_control.sv
hdl/afu_top.sv
dv/afu_tb.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run, and look for the pass message in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module afu_tb -f vlog.f -Mdir obj_dir -o afu_sim > build.log 2>&1 \
	|| { echo "Build failed, see build.log"; exit 1; }

./obj_dir/afu_sim > sim.log 2>&1
grep -qx "Verification passed" sim.log && echo "PASS" \
	|| { echo "FAIL, see sim.log"; exit 1; }
